//--- include/perm_params.svh
// permutation unit sizing macros for lanes, element width, queue depth and ids
`ifndef PERM_PARAMS_SVH
`define PERM_PARAMS_SVH

// lanes per operand row
`define PERM_NR_LANES     4
// bits per lane word
`define PERM_ELEN         64
// element width in bits
`define PERM_EW           16
// instruction queue entries
`define PERM_QUEUE_DEPTH  4
// instruction ids known to the sequencer
`define PERM_NR_VINSN     8

// derived sizes
`define PERM_ELENB        (`PERM_ELEN / 8)
`define PERM_EWB          (`PERM_EW / 8)
`define PERM_ROW_BYTES    (`PERM_NR_LANES * `PERM_ELENB)
`define PERM_NR_ELEM      (`PERM_NR_LANES * `PERM_ELEN / `PERM_EW)
`define PERM_EIDX_W       ($clog2(`PERM_NR_ELEM))
`define PERM_VID_W        ($clog2(`PERM_NR_VINSN))
`define PERM_QPTR_W       ($clog2(`PERM_QUEUE_DEPTH))

`endif

//--- source/perm_pkg.sv
// permutation unit package with request, response, mode and row types
`include "perm_params.svh"

package perm_pkg;

   // lookup mode carried by each instruction
   typedef enum logic [0:0] {
      PERM_GATHER      = 1'b0,
      PERM_GATHER_ZERO = 1'b1
   } perm_mode_e;

   // instruction id
   typedef logic [`PERM_VID_W-1:0] vid_t;

   // request from the main sequencer
   typedef struct packed {
      vid_t       id;
      perm_mode_e mode;
   } perm_req_t;

   // response to the main sequencer, one done bit per id
   typedef struct packed {
      logic [`PERM_NR_VINSN-1:0] vinsn_done;
   } perm_resp_t;

   // operand or result row as the lanes see it
   typedef logic [`PERM_NR_LANES-1:0][`PERM_ELEN-1:0] lane_row_t;

   // sequential row
   // byte view for the shuffle maps, element view for the gather
   typedef union packed {
      logic [`PERM_ROW_BYTES-1:0][7:0]       bytes;
      logic [`PERM_NR_ELEM-1:0][`PERM_EW-1:0] elems;
   } seq_row_u;

   // sequential byte position of byte off in lane word lane
   // elements are dealt round robin over the lanes
   function automatic int seq_byte_idx(int lane, int off);
      return `PERM_EWB * ((off / `PERM_EWB) * `PERM_NR_LANES + lane) + (off % `PERM_EWB);
   endfunction

endpackage

//--- source/perm_ctrl.sv
// permutation control with instruction queue, running id tracking and done response
`timescale 1ns/100ps
`include "perm_params.svh"

module perm_ctrl import perm_pkg::*; (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   // main sequencer
   input  perm_req_t                 pe_req_i,
   input  logic                      pe_req_valid_i,
   input  logic [`PERM_NR_VINSN-1:0] pe_vinsn_running_i,
   output logic                      pe_req_ready_o,
   output perm_resp_t                pe_resp_o,
   // datapath
   input  logic                      operands_done_i,
   input  logic                      result_taken_i,
   output logic                      issue_valid_o,
   output perm_mode_e                issue_mode_o
);

   typedef logic [`PERM_QPTR_W-1:0] qptr_t;
   typedef logic [`PERM_QPTR_W:0]   qcnt_t;

   // pointer step with wrap at the queue depth
   function automatic qptr_t wrap_inc(qptr_t p);
      if (p == qptr_t'(`PERM_QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // instruction queue
   //////////////////////////////////////////////////////////////////////

   perm_req_t queue_q [`PERM_QUEUE_DEPTH];

   // one pointer per phase: accept, issue, commit
   qptr_t accept_pnt_q, issue_pnt_q, commit_pnt_q;

   // issue_cnt counts entries still waiting for operands
   // commit_cnt counts entries whose result is not yet taken
   qcnt_t issue_cnt_q, commit_cnt_q;

   logic [`PERM_NR_VINSN-1:0] running_q, running_d;
   perm_resp_t                resp_d;

   logic queue_full;
   logic accept;
   perm_req_t commit_req;

   assign queue_full = (commit_cnt_q == qcnt_t'(`PERM_QUEUE_DEPTH));

   // refuse an id that the sequencer still sees running
   assign accept = pe_req_valid_i && !queue_full && !running_q[pe_req_i.id];

   assign pe_req_ready_o = !queue_full;
   assign issue_valid_o  = (issue_cnt_q != '0);
   assign issue_mode_o   = queue_q[issue_pnt_q].mode;
   assign commit_req     = queue_q[commit_pnt_q];

   always_comb begin
      // running bits only survive while the sequencer keeps them
      running_d = running_q & pe_vinsn_running_i;
      if (accept) begin
         running_d[pe_req_i.id] = 1'b1;
      end

      // done pulse for the committed id
      resp_d = '0;
      if (result_taken_i) begin
         resp_d.vinsn_done[commit_req.id] = 1'b1;
      end
   end

   // entries are payload, written on accept only
   always_ff @(posedge clk_i) begin
      if (accept) begin
         queue_q[accept_pnt_q] <= pe_req_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         accept_pnt_q <= '0;
         issue_pnt_q  <= '0;
         commit_pnt_q <= '0;
         issue_cnt_q  <= '0;
         commit_cnt_q <= '0;
         running_q    <= '0;
         pe_resp_o    <= '0;
      end else begin
         running_q <= running_d;
         pe_resp_o <= resp_d;

         if (accept) begin
            accept_pnt_q <= wrap_inc(accept_pnt_q);
         end

         // operands complete, move on to the next queued instruction
         if (operands_done_i) begin
            issue_pnt_q <= wrap_inc(issue_pnt_q);
         end

         // result granted, retire the oldest entry
         if (result_taken_i) begin
            commit_pnt_q <= wrap_inc(commit_pnt_q);
         end

         // counters may step up and down in the same cycle
         issue_cnt_q  <= issue_cnt_q + qcnt_t'(accept) - qcnt_t'(operands_done_i);
         commit_cnt_q <= commit_cnt_q + qcnt_t'(accept) - qcnt_t'(result_taken_i);
      end
   end

endmodule

//--- source/perm_operand_buf.sv
// permutation operand buffer taking index and value rows and deshuffling them
`timescale 1ns/100ps
`include "perm_params.svh"

module perm_operand_buf import perm_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_ni,
   // operand source
   input  logic      operand_valid_i,
   input  lane_row_t operand_i,
   output logic      operand_ready_o,
   // control
   input  logic      issue_valid_i,
   input  logic      slot_free_i,
   output logic      operands_done_o,
   // gather unit
   output logic      load_o,
   output seq_row_u  idx_row_o,
   output seq_row_u  val_row_o
);

   //////////////////////////////////////////////////////////////////////
   // beat tracking
   //////////////////////////////////////////////////////////////////////

   // set once the index beat of the current instruction is held
   logic idx_held_q;
   logic beat;

   // index beat needs an issued instruction only
   // value beat also needs room in the result register
   assign operand_ready_o = issue_valid_i && (!idx_held_q || slot_free_i);
   assign beat            = operand_valid_i && operand_ready_o;

   assign operands_done_o = beat && idx_held_q;
   assign load_o          = operands_done_o;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         idx_held_q <= 1'b0;
      end else if (beat) begin
         // index and value beats alternate
         idx_held_q <= !idx_held_q;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // deshuffle
   //////////////////////////////////////////////////////////////////////

   seq_row_u seq_row;
   seq_row_u idx_row_q;

   // lane layout to sequential element order
   always_comb begin
      seq_row = '0;
      for (int l = 0; l < `PERM_NR_LANES; l++) begin
         for (int o = 0; o < `PERM_ELENB; o++) begin
            seq_row.bytes[seq_byte_idx(l, o)] = operand_i[l][8*o +: 8];
         end
      end
   end

   // keep the index row until the value row shows up
   always_ff @(posedge clk_i) begin
      if (beat && !idx_held_q) begin
         idx_row_q <= seq_row;
      end
   end

   assign idx_row_o = idx_row_q;

   // value row goes straight through with the load pulse
   assign val_row_o = seq_row;

endmodule

//--- source/perm_gather_unit.sv
// permutation gather unit selecting elements by index and holding the result
`timescale 1ns/100ps
`include "perm_params.svh"

module perm_gather_unit import perm_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   // operand buffer
   input  logic       load_i,
   input  seq_row_u   idx_row_i,
   input  seq_row_u   val_row_i,
   output logic       slot_free_o,
   // control
   input  perm_mode_e mode_i,
   output logic       result_taken_o,
   // result port
   input  logic       permu_result_gnt_i,
   output logic       permu_result_valid_o,
   output lane_row_t  permu_result_wdata_o
);

   //////////////////////////////////////////////////////////////////////
   // gather
   //////////////////////////////////////////////////////////////////////

   seq_row_u  gath_row;
   lane_row_t shuf_row;

   always_comb begin : gather
      logic [`PERM_EIDX_W-1:0] sel;
      logic                    oob;
      gath_row = '0;
      for (int k = 0; k < `PERM_NR_ELEM; k++) begin
         // low bits pick the element, so plain gather wraps mod row size
         sel = idx_row_i.elems[k][`PERM_EIDX_W-1:0];
         // any upper bit set means the index is past the row
         oob = |idx_row_i.elems[k][`PERM_EW-1:`PERM_EIDX_W];
         if (mode_i == PERM_GATHER_ZERO && oob) begin
            gath_row.elems[k] = '0;
         end else begin
            gath_row.elems[k] = val_row_i.elems[sel];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // reshuffle
   //////////////////////////////////////////////////////////////////////

   // inverse of the deshuffle, back to lane layout
   always_comb begin
      shuf_row = '0;
      for (int l = 0; l < `PERM_NR_LANES; l++) begin
         for (int o = 0; o < `PERM_ELENB; o++) begin
            shuf_row[l][8*o +: 8] = gath_row.bytes[seq_byte_idx(l, o)];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // result register
   //////////////////////////////////////////////////////////////////////

   logic      res_valid_q;
   lane_row_t res_data_q;

   assign result_taken_o = res_valid_q && permu_result_gnt_i;

   // room for a new result when empty or leaving this cycle
   assign slot_free_o = !res_valid_q || permu_result_gnt_i;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         res_valid_q <= 1'b0;
      end else if (load_i) begin
         // a load in the grant cycle keeps valid high
         res_valid_q <= 1'b1;
      end else if (permu_result_gnt_i) begin
         res_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_i) begin
         res_data_q <= shuf_row;
      end
   end

   assign permu_result_valid_o = res_valid_q;
   assign permu_result_wdata_o = res_data_q;

endmodule

//--- source/perm_unit_top.sv
// permutation unit top connecting control, operand buffer and gather unit
`timescale 1ns/100ps
`include "perm_params.svh"

module perm_unit_top import perm_pkg::*; (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   // main sequencer
   input  perm_req_t                 pe_req_i,
   input  logic                      pe_req_valid_i,
   input  logic [`PERM_NR_VINSN-1:0] pe_vinsn_running_i,
   output logic                      pe_req_ready_o,
   output perm_resp_t                pe_resp_o,
   // operands
   input  logic                      operand_valid_i,
   input  lane_row_t                 operand_i,
   output logic                      operand_ready_o,
   // result
   input  logic                      permu_result_gnt_i,
   output logic                      permu_result_valid_o,
   output lane_row_t                 permu_result_wdata_o
);

   // control to datapath
   logic       issue_valid;
   perm_mode_e issue_mode;
   // datapath to control
   logic       operands_done;
   logic       result_taken;
   // operand buffer to gather unit
   logic       load;
   logic       slot_free;
   seq_row_u   idx_row;
   seq_row_u   val_row;

   perm_ctrl u_ctrl (
      .clk_i              (clk_i),
      .rst_ni             (rst_ni),
      .pe_req_i           (pe_req_i),
      .pe_req_valid_i     (pe_req_valid_i),
      .pe_vinsn_running_i (pe_vinsn_running_i),
      .pe_req_ready_o     (pe_req_ready_o),
      .pe_resp_o          (pe_resp_o),
      .operands_done_i    (operands_done),
      .result_taken_i     (result_taken),
      .issue_valid_o      (issue_valid),
      .issue_mode_o       (issue_mode)
   );

   perm_operand_buf u_operand_buf (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .operand_valid_i (operand_valid_i),
      .operand_i       (operand_i),
      .operand_ready_o (operand_ready_o),
      .issue_valid_i   (issue_valid),
      .slot_free_i     (slot_free),
      .operands_done_o (operands_done),
      .load_o          (load),
      .idx_row_o       (idx_row),
      .val_row_o       (val_row)
   );

   perm_gather_unit u_gather_unit (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .load_i               (load),
      .idx_row_i            (idx_row),
      .val_row_i            (val_row),
      .slot_free_o          (slot_free),
      .mode_i               (issue_mode),
      .result_taken_o       (result_taken),
      .permu_result_gnt_i   (permu_result_gnt_i),
      .permu_result_valid_o (permu_result_valid_o),
      .permu_result_wdata_o (permu_result_wdata_o)
   );

endmodule

//--- verification/tb_clk_gen.sv
// testbench clock and reset source for the permutation unit
`timescale 1ns/100ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_no
);

   localparam int unsigned HALF_PERIOD  = 10;
   localparam int unsigned RESET_CYCLES = 16;

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever begin
         #HALF_PERIOD clk_o = ~clk_o;
      end
   end

   // reset low for the first rising edges, released on an edge
   initial begin
      rst_no = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_no <= 1'b1;
   end

endmodule

//--- verification/perm_unit_asserts.sv
// concurrent checks on the permutation unit handshakes and done pulses
`timescale 1ns/100ps
`include "perm_params.svh"

module perm_unit_asserts import perm_pkg::*; (
   input logic       clk_i,
   input logic       rst_ni,
   input logic       operand_valid_i,
   input logic       operand_ready_o,
   input logic       permu_result_gnt_i,
   input logic       permu_result_valid_o,
   input lane_row_t  permu_result_wdata_o,
   input perm_resp_t pe_resp_o
);

   // held result keeps valid and data until its grant
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      permu_result_valid_o && !permu_result_gnt_i |=>
         permu_result_valid_o && $stable(permu_result_wdata_o))
      else $error("result moved before grant");

   // a result only appears after an operand beat taken with ready
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(permu_result_valid_o) |-> $past(operand_valid_i && operand_ready_o))
      else $error("result without an operand handshake");

   // each done bit is a single cycle pulse
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      (pe_resp_o.vinsn_done & $past(pe_resp_o.vinsn_done)) == '0)
      else $error("done bit high for more than one cycle");

endmodule

//--- verification/tb_perm_unit.sv
// testbench for the permutation unit with directed tests and a row model
`timescale 1ns/100ps
`include "perm_params.svh"

module tb_perm_unit import perm_pkg::*; ();

   localparam int unsigned TIMEOUT = 200;
   localparam int unsigned SEED    = 32'hf6e1_9852;
   localparam int L  = `PERM_NR_LANES;
   localparam int EW = `PERM_EW;
   localparam int NE = `PERM_NR_ELEM;
   // index row kinds
   localparam int IDX_IDENTITY = 0;
   localparam int IDX_REVERSE  = 1;
   localparam int IDX_RANDOM   = 2;

   logic                      clk;
   logic                      rst_n;
   perm_req_t                 req;
   logic                      req_valid;
   logic                      req_ready;
   logic [`PERM_NR_VINSN-1:0] running;
   perm_resp_t                resp;
   logic                      op_valid;
   logic                      op_ready;
   lane_row_t                 operand;
   logic                      gnt;
   logic                      res_valid;
   lane_row_t                 res_data;

   int    errors;
   int    test_start_errors;
   int    tests_run;
   int    tests_bad;
   string test_name;

   tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

   perm_unit_top u_dut (
      .clk_i                (clk),
      .rst_ni               (rst_n),
      .pe_req_i             (req),
      .pe_req_valid_i       (req_valid),
      .pe_vinsn_running_i   (running),
      .pe_req_ready_o       (req_ready),
      .pe_resp_o            (resp),
      .operand_valid_i      (op_valid),
      .operand_i            (operand),
      .operand_ready_o      (op_ready),
      .permu_result_gnt_i   (gnt),
      .permu_result_valid_o (res_valid),
      .permu_result_wdata_o (res_data)
   );

   bind perm_unit_top perm_unit_asserts u_asserts (.*);

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // element e lives in lane e mod lanes, slot e / lanes of that lane
   function automatic logic [EW-1:0] lane_elem(lane_row_t row, int e);
      return row[e % L][EW*(e / L) +: EW];
   endfunction

   function automatic lane_row_t model_gather(lane_row_t idx, lane_row_t val, perm_mode_e mode);
      lane_row_t     res;
      logic [EW-1:0] ix;
      res = '0;
      for (int k = 0; k < NE; k++) begin
         ix = lane_elem(idx, k);
         // zero mode leaves the element at zero past the row end
         if (!(mode == PERM_GATHER_ZERO && ix >= NE)) begin
            res[k % L][EW*(k / L) +: EW] = lane_elem(val, int'(ix) % NE);
         end
      end
      return res;
   endfunction

   function automatic lane_row_t make_idx_row(int kind);
      lane_row_t     row;
      logic [EW-1:0] v;
      row = '0;
      for (int k = 0; k < NE; k++) begin
         case (kind)
            IDX_IDENTITY: v = EW'(k);
            IDX_REVERSE:  v = EW'(NE - 1 - k);
            default:      v = EW'($urandom_range(2 * NE - 1));
         endcase
         row[k % L][EW*(k / L) +: EW] = v;
      end
      return row;
   endfunction

   function automatic lane_row_t random_row();
      lane_row_t row;
      for (int l = 0; l < L; l++) begin
         row[l] = {$urandom, $urandom};
      end
      return row;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // compare tasks and bookkeeping
   //////////////////////////////////////////////////////////////////////

   task automatic check_row(string name, lane_row_t exp, lane_row_t act);
      if (act !== exp) begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_resp(string name, perm_resp_t exp, perm_resp_t act);
      if (act !== exp) begin
         $display("ERROR %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("ERROR %s expected %b actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic begin_test(string name);
      test_name         = name;
      test_start_errors = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == test_start_errors) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d mismatches", test_name, errors - test_start_errors);
         tests_bad++;
      end
   endtask

   task automatic abort_run(string what);
      $display("timeout in test %s while waiting for %s", test_name, what);
      $display("tests failed");
      $finish;
   endtask

   //////////////////////////////////////////////////////////////////////
   // bus tasks
   //////////////////////////////////////////////////////////////////////

   // request stays valid until it is taken on a ready edge
   task automatic send_req(vid_t req_id, perm_mode_e req_mode);
      int n;
      n = 0;
      @(posedge clk);
      req       <= '{id: req_id, mode: req_mode};
      req_valid <= 1'b1;
      @(negedge clk);
      while (!req_ready) begin
         n++;
         if (n > TIMEOUT) begin
            abort_run("request ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
      req_valid <= 1'b0;
   endtask

   // returns just after the transfer edge
   task automatic send_beat(lane_row_t row);
      int n;
      n = 0;
      @(posedge clk);
      operand  <= row;
      op_valid <= 1'b1;
      @(negedge clk);
      while (!op_ready) begin
         n++;
         if (n > TIMEOUT) begin
            abort_run("operand ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
      op_valid <= 1'b0;
   endtask

   task automatic wait_result();
      int n;
      n = 0;
      @(negedge clk);
      while (!res_valid) begin
         n++;
         if (n > TIMEOUT) begin
            abort_run("result valid");
         end
         @(negedge clk);
      end
   endtask

   // one grant cycle, then the done pulse for the id
   task automatic grant_result(vid_t id, string name);
      perm_resp_t exp;
      exp = '0;
      exp.vinsn_done[id] = 1'b1;
      @(posedge clk);
      gnt <= 1'b1;
      // nothing reported before the granting edge
      @(negedge clk);
      check_resp({name, " done early"}, '0, resp);
      @(posedge clk);
      gnt <= 1'b0;
      @(negedge clk);
      check_resp({name, " done"}, exp, resp);
      @(negedge clk);
      check_resp({name, " done cleared"}, '0, resp);
   endtask

   task automatic run_insn(vid_t id, perm_mode_e mode, lane_row_t idx, lane_row_t val,
                           string name);
      send_req(id, mode);
      send_beat(idx);
      send_beat(val);
      wait_result();
      check_row(name, model_gather(idx, val, mode), res_data);
      grant_result(id, name);
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      begin_test("reset_values");
      @(negedge clk);
      check_bit("reset req ready", 1'b1, req_ready);
      check_bit("reset operand ready", 1'b0, op_ready);
      check_bit("reset result valid", 1'b0, res_valid);
      check_resp("reset resp", '0, resp);
      end_test();
   endtask

   task automatic test_identity_reverse();
      lane_row_t val;
      begin_test("identity_reverse");
      val = random_row();
      send_req(3'd1, PERM_GATHER);
      send_beat(make_idx_row(IDX_IDENTITY));
      send_beat(val);
      wait_result();
      // identity gather hands back the value row itself
      check_row("identity", val, res_data);
      grant_result(3'd1, "identity");
      val = random_row();
      run_insn(3'd2, PERM_GATHER, make_idx_row(IDX_REVERSE), val, "reverse");
      end_test();
   endtask

   task automatic test_zero_wrap();
      lane_row_t idx;
      lane_row_t val;
      begin_test("zero_and_wrap");
      idx = make_idx_row(IDX_RANDOM);
      val = random_row();
      run_insn(3'd3, PERM_GATHER_ZERO, idx, val, "gather zero");
      run_insn(3'd4, PERM_GATHER, idx, val, "gather wrap");
      end_test();
   endtask

   task automatic test_latency();
      lane_row_t idx;
      lane_row_t val;
      begin_test("latency");
      idx = make_idx_row(IDX_RANDOM);
      val = random_row();
      send_req(3'd5, PERM_GATHER);
      send_beat(idx);
      @(negedge clk);
      check_bit("valid before value beat", 1'b0, res_valid);
      send_beat(val);
      @(negedge clk);
      check_bit("valid one cycle after value beat", 1'b1, res_valid);
      check_row("latency data", model_gather(idx, val, PERM_GATHER), res_data);
      grant_result(3'd5, "latency");
      check_bit("valid after grant", 1'b0, res_valid);
      end_test();
   endtask

   task automatic test_backpressure();
      lane_row_t  idx1, val1, idx2, val2;
      lane_row_t  exp1;
      perm_resp_t done6;
      begin_test("backpressure");
      idx1  = make_idx_row(IDX_RANDOM);
      val1  = random_row();
      idx2  = make_idx_row(IDX_RANDOM);
      val2  = random_row();
      exp1  = model_gather(idx1, val1, PERM_GATHER);
      done6 = '0;
      done6.vinsn_done[6] = 1'b1;
      send_req(3'd6, PERM_GATHER);
      send_req(3'd7, PERM_GATHER_ZERO);
      send_beat(idx1);
      send_beat(val1);
      wait_result();
      check_row("first result", exp1, res_data);
      // second index beat still goes in while the first result waits
      send_beat(idx2);
      @(posedge clk);
      operand  <= val2;
      op_valid <= 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_bit("value beat refused", 1'b0, op_ready);
         check_bit("first result valid held", 1'b1, res_valid);
         check_row("first result held", exp1, res_data);
      end
      @(posedge clk);
      gnt <= 1'b1;
      @(negedge clk);
      check_bit("value beat with grant", 1'b1, op_ready);
      @(posedge clk);
      gnt      <= 1'b0;
      op_valid <= 1'b0;
      @(negedge clk);
      check_resp("first done", done6, resp);
      check_bit("second result valid", 1'b1, res_valid);
      check_row("second result", model_gather(idx2, val2, PERM_GATHER_ZERO), res_data);
      grant_result(3'd7, "second");
      end_test();
   endtask

   task automatic test_queue_running();
      lane_row_t idx_rows [`PERM_QUEUE_DEPTH];
      lane_row_t val_rows [`PERM_QUEUE_DEPTH];
      lane_row_t idx;
      lane_row_t val;
      int        n;
      begin_test("queue_and_running");
      for (int i = 0; i < `PERM_QUEUE_DEPTH; i++) begin
         idx_rows[i] = make_idx_row(IDX_RANDOM);
         val_rows[i] = random_row();
         send_req(vid_t'(i), perm_mode_e'(i % 2));
      end
      @(negedge clk);
      check_bit("full queue ready", 1'b0, req_ready);
      for (int i = 0; i < `PERM_QUEUE_DEPTH; i++) begin
         send_beat(idx_rows[i]);
         send_beat(val_rows[i]);
         wait_result();
         check_row("queued result",
                   model_gather(idx_rows[i], val_rows[i], perm_mode_e'(i % 2)), res_data);
         grant_result(vid_t'(i), "queued");
      end
      check_bit("drained queue ready", 1'b1, req_ready);

      // sequencer keeps id 2 running past its first completion
      @(posedge clk);
      running[2] <= 1'b1;
      run_insn(3'd2, PERM_GATHER, make_idx_row(IDX_REVERSE), random_row(), "running first");
      @(posedge clk);
      req       <= '{id: 3'd2, mode: PERM_GATHER};
      req_valid <= 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_bit("running id not issued", 1'b0, op_ready);
      end
      @(posedge clk);
      running[2] <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!op_ready) begin
         n++;
         if (n > TIMEOUT) begin
            abort_run("issue after running clear");
         end
         @(negedge clk);
      end
      @(posedge clk);
      req_valid <= 1'b0;
      idx = make_idx_row(IDX_RANDOM);
      val = random_row();
      send_beat(idx);
      send_beat(val);
      wait_result();
      check_row("running second", model_gather(idx, val, PERM_GATHER), res_data);
      grant_result(3'd2, "running second");
      check_bit("single accept", 1'b0, op_ready);
      end_test();
   endtask

   //////////////////////////////////////////////////////////////////////
   // sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int n;
      void'($urandom(SEED));
      req               = '0;
      req_valid         = 1'b0;
      running           = '0;
      op_valid          = 1'b0;
      operand           = '0;
      gnt               = 1'b0;
      errors            = 0;
      test_start_errors = 0;
      tests_run         = 0;
      tests_bad         = 0;
      test_name         = "startup";
      n                 = 0;
      while (rst_n !== 1'b1) begin
         n++;
         if (n > TIMEOUT) begin
            abort_run("reset release");
         end
         @(posedge clk);
      end
      test_reset();
      test_identity_reverse();
      test_zero_wrap();
      test_latency();
      test_backpressure();
      test_queue_running();
      $display("tests run %0d, with mismatches %0d, mismatches total %0d",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+include
source/perm_pkg.sv
source/perm_ctrl.sv
source/perm_operand_buf.sv
source/perm_gather_unit.sv
source/perm_unit_top.sv
verification/tb_clk_gen.sv
verification/perm_unit_asserts.sv
verification/tb_perm_unit.sv

//--- run.sh
#!/bin/sh
# build and run the permutation unit testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_perm_unit -f filelist.f \
   && ./obj_dir/Vtb_perm_unit > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
